//--- led_defs.svh
`ifndef LED_DEFS_SVH
`define LED_DEFS_SVH

// ##############################
// panel geometry
// ##############################

`define LED_NUM         8
`define LED_FIELD_W     4

// ##############################
// periods, in clk cycles
// ##############################

// spark half-period
`define SPARK_MAX       64

// bling half-period, counted only while the channel enable is high
`define BLING_MAX       8

// clk cycles per shcp phase
`define SHIFT_DIV       2

`endif

//--- led_mode_pkg.sv
`include "led_defs.svh"

package led_mode_pkg;

        // per-LED mode codes, anything else holds the current level
        typedef enum logic [`LED_FIELD_W-1:0] {
                LED_OFF    = 0,
                LED_ON     = 1,
                LED_SPARK  = 2,
                LED_SPARK1 = 3,
                LED_BLING  = 4
        } led_mode_e;

        // full panel mode word, led0 in the low nibble
        typedef struct packed {
                led_mode_e led7;
                led_mode_e led6;
                led_mode_e led5;
                led_mode_e led4;
                led_mode_e led3;
                led_mode_e led2;
                led_mode_e led1;
                led_mode_e led0;
        } led_modes_t;

        function automatic led_mode_e field_of(input led_modes_t word, input int unsigned idx);
                return led_mode_e'(word[idx*`LED_FIELD_W +: `LED_FIELD_W]);
        endfunction

endpackage

//--- led_link_pkg.sv
`include "led_defs.svh"

package led_link_pkg;

        // one pattern frame, bit 7 goes out first
        typedef struct packed {
                logic [`LED_NUM-1:0] bits;
        } led_frame_t;

        // serializer states
        typedef enum logic [1:0] {
                IDLE  = 2'd0,
                SHIFT = 2'd1,
                LATCH = 2'd2
        } shift_state_e;

endpackage

//--- led_host_port.sv
`timescale 1ns/1ps

module led_host_port (
        input  logic                     clk,
        input  logic                     rst,
        input  logic                     req,
        input  led_mode_pkg::led_modes_t wr_modes,
        output logic                     ack,
        output logic                     upd,
        output led_mode_pkg::led_modes_t modes
);

        logic take;

        // new request seen while ack is still low
        assign take = req && !ack;

        // four-phase slave, ack follows req by one cycle
        always_ff @(posedge clk) begin
                if (rst) begin
                        ack <= 1'b0;
                        upd <= 1'b0;
                end else begin
                        ack <= req;
                        upd <= take;
                end
        end

        // mode word register, all LEDs off after reset
        always_ff @(posedge clk) begin
                if (rst) begin
                        modes <= '0;
                end else if (take) begin
                        modes <= wr_modes;
                end
        end

        // ack only rises while the host still holds req
        a_ack_rise: assert property (
                @(posedge clk) disable iff (rst)
                $rose(ack) |-> req
        );

endmodule

//--- led_ctrl.sv
`timescale 1ns/1ps
`include "led_defs.svh"

module led_ctrl (
        input  logic                     clk,
        input  logic                     rst,
        input  logic                     upd,
        input  led_mode_pkg::led_modes_t modes,
        input  logic [3:0]               led_bling,
        input  logic                     busy,
        output logic                     start,
        output led_link_pkg::led_frame_t frame
);

        localparam int N     = `LED_NUM;
        localparam int CNT_W = $clog2(`SPARK_MAX + 1);
        localparam logic [CNT_W-1:0] SPARK_END = CNT_W'(`SPARK_MAX);
        localparam logic [CNT_W-1:0] BLING_END = CNT_W'(`BLING_MAX);

        led_mode_pkg::led_modes_t prev_modes;
        logic [N-1:0] flip;
        logic [N-1:0] pat_next;
        logic         req_now;
        logic         pending;
        logic         fire;

        // last applied word, for change detect
        always_ff @(posedge clk) begin
                if (rst) begin
                        prev_modes <= '0;
                end else if (upd) begin
                        prev_modes <= modes;
                end
        end

        // ##############################
        // per-LED mode logic
        // ##############################

        for (genvar i = 0; i < N; i++) begin : g_led
                led_mode_pkg::led_mode_e mode;
                logic             changed;
                logic             bling_en;
                logic             is_bling;
                logic             is_rep;
                logic             fixed;
                logic             fixed_val;
                logic             step;
                logic             hit;
                logic [CNT_W-1:0] cnt;
                logic [CNT_W-1:0] cnt_run;

                assign mode    = led_mode_pkg::field_of(modes, i);
                assign changed = (mode != led_mode_pkg::field_of(prev_modes, i));

                // only LEDs 2 to 5 know bling
                if (i >= 2 && i <= 5) begin : g_bling
                        assign bling_en = led_bling[i-2];
                        assign is_bling = (mode == led_mode_pkg::LED_BLING);
                end else begin : g_plain
                        assign bling_en = 1'b0;
                        assign is_bling = 1'b0;
                end

                assign is_rep    = (mode == led_mode_pkg::LED_SPARK1) || is_bling;
                assign fixed     = mode inside {led_mode_pkg::LED_OFF, led_mode_pkg::LED_ON,
                                                led_mode_pkg::LED_SPARK};
                assign fixed_val = (mode != led_mode_pkg::LED_OFF);
                assign step      = is_bling ? bling_en : 1'b1;
                assign hit       = step && (cnt == (is_bling ? BLING_END : SPARK_END));

                // free-running next count
                always_comb begin
                        if (hit) begin
                                cnt_run = is_rep ? CNT_W'(1) : '0;
                        end else if (cnt != '0 && step) begin
                                cnt_run = cnt + 1'b1;
                        end else begin
                                cnt_run = cnt;
                        end
                end

                always_ff @(posedge clk) begin
                        if (rst) begin
                                cnt <= '0;
                        end else if (upd) begin
                                if (mode == led_mode_pkg::LED_SPARK || (is_rep && changed)) begin
                                        cnt <= CNT_W'(1);
                                end else if (is_rep) begin
                                        cnt <= cnt_run;
                                end else begin
                                        cnt <= '0;
                                end
                        end else begin
                                cnt <= cnt_run;
                        end
                end

                // unchanged repeating LEDs keep toggling across a rewrite
                assign flip[i]     = hit && (!upd || (is_rep && !changed));
                assign pat_next[i] = (upd && fixed) ? fixed_val : (frame.bits[i] ^ flip[i]);
        end

        // ##############################
        // frame request to serializer
        // ##############################

        assign req_now = upd || (|flip);
        assign fire    = pending && !busy;

        always_ff @(posedge clk) begin
                if (rst) begin
                        frame   <= '0;
                        start   <= 1'b0;
                        pending <= 1'b0;
                end else begin
                        frame.bits <= pat_next;
                        start      <= fire;
                        // updates before the copy edge ride along in this frame
                        pending    <= fire ? 1'b0 : (pending || req_now);
                end
        end

        // serializer is free at start and takes the frame right after
        a_start_idle: assert property (
                @(posedge clk) disable iff (rst)
                start |-> !busy ##1 busy
        );

endmodule

//--- led_shift.sv
`timescale 1ns/1ps
`include "led_defs.svh"

module led_shift (
        input  logic                     clk,
        input  logic                     rst,
        input  logic                     start,
        input  led_link_pkg::led_frame_t frame,
        output logic                     busy,
        output logic                     shcp,
        output logic                     ds,
        output logic                     stcp
);

        localparam int DIV_W = $clog2(2 * `SHIFT_DIV);
        localparam int BIT_W = $clog2(`LED_NUM);
        localparam logic [DIV_W-1:0] DIV_HIGH = DIV_W'(`SHIFT_DIV);
        localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(2 * `SHIFT_DIV - 1);
        localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`LED_NUM - 1);

        led_link_pkg::shift_state_e state;
        logic [DIV_W-1:0]   div_cnt;
        logic [BIT_W-1:0]   bit_cnt;
        logic [`LED_NUM-1:0] sreg;
        logic               bit_end;

        // last cycle of the shcp high phase
        assign bit_end = (div_cnt == DIV_LAST);

        // ##############################
        // FSM and counters
        // ##############################

        always_ff @(posedge clk) begin
                if (rst) begin
                        state   <= led_link_pkg::IDLE;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                end else begin
                        case (state)
                                led_link_pkg::IDLE: begin
                                        if (start) begin
                                                state   <= led_link_pkg::SHIFT;
                                                div_cnt <= '0;
                                                bit_cnt <= '0;
                                        end
                                end
                                led_link_pkg::SHIFT: begin
                                        div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
                                        if (bit_end) begin
                                                bit_cnt <= bit_cnt + 1'b1;
                                                if (bit_cnt == BIT_LAST) begin
                                                        state <= led_link_pkg::LATCH;
                                                end
                                        end
                                end
                                default: begin
                                        state <= led_link_pkg::IDLE;
                                end
                        endcase
                end
        end

        // data shifter, msb first
        always_ff @(posedge clk) begin
                if (state == led_link_pkg::IDLE && start) begin
                        sreg <= frame.bits;
                end else if (state == led_link_pkg::SHIFT && bit_end) begin
                        sreg <= {sreg[`LED_NUM-2:0], 1'b0};
                end
        end

        assign busy = (state != led_link_pkg::IDLE);
        assign shcp = (state == led_link_pkg::SHIFT) && (div_cnt >= DIV_HIGH);
        assign ds   = (state == led_link_pkg::SHIFT) && sreg[`LED_NUM-1];
        assign stcp = (state == led_link_pkg::LATCH);

        // single-cycle latch pulse right after the last bit
        a_stcp_pulse: assert property (
                @(posedge clk) disable iff (rst)
                stcp |-> $past(state) == led_link_pkg::SHIFT && $past(bit_cnt) == BIT_LAST
        );

endmodule

//--- led_panel_top.sv
`timescale 1ns/1ps

module led_panel_top (
        input  logic                     clk,
        input  logic                     rst,
        input  logic                     req,
        input  led_mode_pkg::led_modes_t wr_modes,
        output logic                     ack,
        input  logic [3:0]               led_bling,
        output logic                     shcp,
        output logic                     ds,
        output logic                     stcp
);

        logic                     upd;
        led_mode_pkg::led_modes_t modes;
        logic                     start;
        logic                     busy;
        led_link_pkg::led_frame_t frame;

        led_host_port u_host_port (
                .clk      (clk),
                .rst      (rst),
                .req      (req),
                .wr_modes (wr_modes),
                .ack      (ack),
                .upd      (upd),
                .modes    (modes)
        );

        led_ctrl u_ctrl (
                .clk       (clk),
                .rst       (rst),
                .upd       (upd),
                .modes     (modes),
                .led_bling (led_bling),
                .busy      (busy),
                .start     (start),
                .frame     (frame)
        );

        led_shift u_shift (
                .clk   (clk),
                .rst   (rst),
                .start (start),
                .frame (frame),
                .busy  (busy),
                .shcp  (shcp),
                .ds    (ds),
                .stcp  (stcp)
        );

endmodule

//--- tb_led_check.sv
`timescale 1ns/1ps
`include "led_defs.svh"

module tb_led_check (
        input logic clk,
        input logic rst,
        input logic shcp,
        input logic ds,
        input logic stcp
);

        logic [`LED_NUM-1:0] shreg = '0;
        led_link_pkg::led_frame_t frames[$];
        led_link_pkg::led_frame_t cap;
        int errors = 0;
        int checks = 0;

        // ##############################
        // frame capture from the pins
        // ##############################

        always @(posedge shcp) begin
                shreg <= {shreg[`LED_NUM-2:0], ds};
        end

        always @(posedge clk) begin
                if (!rst && stcp) begin
                        cap.bits = shreg;
                        frames.push_back(cap);
                end
        end

        // expected pattern after a write: off, on/spark, else hold
        function automatic led_link_pkg::led_frame_t ref_frame(
                input led_mode_pkg::led_modes_t w,
                input led_link_pkg::led_frame_t prev);
                led_link_pkg::led_frame_t f;
                logic [`LED_FIELD_W-1:0] code;
                f = prev;
                for (int i = 0; i < `LED_NUM; i++) begin
                        code = w[i*`LED_FIELD_W +: `LED_FIELD_W];
                        if (code == 0) begin
                                f.bits[i] = 1'b0;
                        end else if (code == 1 || code == 2) begin
                                f.bits[i] = 1'b1;
                        end
                end
                return f;
        endfunction

        task automatic check_frame(input string name, input led_link_pkg::led_frame_t got,
                                   input led_link_pkg::led_frame_t exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("Error at %0t: %s got %h expected %h", $realtime, name,
                                 got.bits, exp.bits);
                end
        endtask

        task automatic check_bit(input string name, input logic got, input logic exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("Error at %0t: %s got %b expected %b", $realtime, name, got, exp);
                end
        endtask

        task automatic fail(input string what);
                errors++;
                $display("at %0t: %s", $realtime, what);
        endtask

endmodule

//--- tb_led_panel.sv
`timescale 1ns/1ps
`include "led_defs.svh"

module tb_led_panel;

        logic clk = 1'b0;
        logic rst = 1'b1;
        logic req = 1'b0;
        led_mode_pkg::led_modes_t wr_modes = '0;
        logic [3:0] led_bling = 4'b0000;
        logic ack;
        logic shcp;
        logic ds;
        logic stcp;

        logic [31:0] lfsr = 32'h6d65;
        int cyc = 0;
        int t0;
        logic b;
        logic ok;
        led_mode_pkg::led_modes_t word;
        led_link_pkg::led_frame_t last_f;
        led_link_pkg::led_frame_t exp_f;
        led_link_pkg::led_frame_t got_f;

        led_panel_top dut (
                .clk       (clk),
                .rst       (rst),
                .req       (req),
                .wr_modes  (wr_modes),
                .ack       (ack),
                .led_bling (led_bling),
                .shcp      (shcp),
                .ds        (ds),
                .stcp      (stcp)
        );

        tb_led_check chk (
                .clk  (clk),
                .rst  (rst),
                .shcp (shcp),
                .ds   (ds),
                .stcp (stcp)
        );

        always #4 clk = ~clk;

        always @(posedge clk) begin
                cyc <= cyc + 1;
        end

        // taps 32 22 2 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic take_bit(output logic bit_out);
                lfsr = lfsr_next(lfsr);
                bit_out = lfsr[0];
        endtask

        // ##############################
        // host link and frame waits
        // ##############################

        task automatic host_write(input led_mode_pkg::led_modes_t w);
                int n;
                @(posedge clk);
                req <= 1'b1;
                wr_modes <= w;
                n = 0;
                while (ack !== 1'b1 && n < 20) begin
                        @(negedge clk);
                        n++;
                end
                if (ack !== 1'b1) begin
                        chk.fail("ack did not rise after req");
                end
                @(posedge clk);
                req <= 1'b0;
                n = 0;
                while (ack !== 1'b0 && n < 20) begin
                        @(negedge clk);
                        n++;
                end
                chk.check_bit("ack", ack, 1'b0);
        endtask

        task automatic wait_frame(input int limit, output led_link_pkg::led_frame_t f,
                                  output logic got);
                int n;
                n = 0;
                got = 1'b0;
                f = '0;
                while (chk.frames.size() == 0 && n < limit) begin
                        @(negedge clk);
                        n++;
                end
                if (chk.frames.size() != 0) begin
                        f = chk.frames.pop_front();
                        got = 1'b1;
                end else begin
                        chk.fail("timeout waiting for a frame");
                end
        endtask

        task automatic no_frame(input int cycles);
                int n;
                n = 0;
                while (chk.frames.size() == 0 && n < cycles) begin
                        @(negedge clk);
                        n++;
                end
                if (chk.frames.size() != 0) begin
                        chk.fail("unexpected frame on the serial pins");
                        chk.frames.delete();
                end
        endtask

        // expect n frames with one bit toggling each time
        task automatic toggle_frames(input int idx, input int n);
                for (int k = 0; k < n; k++) begin
                        wait_frame(4 * `SPARK_MAX, got_f, ok);
                        exp_f = last_f;
                        exp_f.bits[idx] = ~last_f.bits[idx];
                        chk.check_frame("frame", got_f, exp_f);
                        last_f = exp_f;
                end
        endtask

        // merged frames may skip a toggle, so only count the changes
        task automatic count_flips(input int idx, input int n);
                int flips;
                int k;
                flips = 0;
                k = 0;
                ok = 1'b1;
                while (ok && flips < n && k < 4 * n) begin
                        wait_frame(4 * `SPARK_MAX, got_f, ok);
                        if (ok) begin
                                exp_f = last_f;
                                exp_f.bits[idx] = got_f.bits[idx];
                                chk.check_frame("frame", got_f, exp_f);
                                if (got_f.bits[idx] != last_f.bits[idx]) begin
                                        flips++;
                                end
                                last_f = exp_f;
                        end
                        k++;
                end
                if (flips < n) begin
                        chk.fail("bling bit did not alternate between frames");
                end
        endtask

        initial begin
                last_f = '0;
                word = '0;
                repeat (16) @(posedge clk);
                rst <= 1'b0;
                @(negedge clk);
                chk.check_bit("ack", ack, 1'b0);
                chk.check_bit("shcp", shcp, 1'b0);
                chk.check_bit("ds", ds, 1'b0);
                chk.check_bit("stcp", stcp, 1'b0);
                no_frame(100);

                // random on/off words
                for (int r = 0; r < 4; r++) begin
                        for (int i = 0; i < `LED_NUM; i++) begin
                                take_bit(b);
                                word[i*`LED_FIELD_W +: `LED_FIELD_W] = b ? led_mode_pkg::LED_ON
                                                                         : led_mode_pkg::LED_OFF;
                        end
                        host_write(word);
                        wait_frame(200, got_f, ok);
                        exp_f = chk.ref_frame(word, last_f);
                        chk.check_frame("frame", got_f, exp_f);
                        last_f = exp_f;
                        no_frame(4 * `SPARK_MAX);
                end

                // one-shot spark on led0
                word.led0 = led_mode_pkg::LED_SPARK;
                host_write(word);
                wait_frame(200, got_f, ok);
                exp_f = chk.ref_frame(word, last_f);
                chk.check_frame("frame", got_f, exp_f);
                last_f = exp_f;
                toggle_frames(0, 1);
                chk.check_bit("frame bit 0", got_f.bits[0], 1'b0);
                no_frame(4 * `SPARK_MAX);

                // repeating spark on led1
                word.led0 = led_mode_pkg::LED_OFF;
                word.led1 = led_mode_pkg::LED_SPARK1;
                host_write(word);
                wait_frame(200, got_f, ok);
                exp_f = chk.ref_frame(word, last_f);
                chk.check_frame("frame", got_f, exp_f);
                last_f = exp_f;
                toggle_frames(1, 4);
                t0 = cyc;
                host_write(word);
                // the rewrite frame itself holds the level
                ok = 1'b1;
                while (ok && got_f.bits[1] == last_f.bits[1] && cyc - t0 < 4 * `SPARK_MAX) begin
                        wait_frame(4 * `SPARK_MAX, got_f, ok);
                        exp_f = last_f;
                        exp_f.bits[1] = got_f.bits[1];
                        chk.check_frame("frame", got_f, exp_f);
                end
                last_f = got_f;
                if (cyc - t0 > `SPARK_MAX + 20) begin
                        chk.fail("rewrite of the same word restarted the spark period");
                end
                word.led1 = led_mode_pkg::LED_OFF;
                host_write(word);
                wait_frame(200, got_f, ok);
                exp_f = chk.ref_frame(word, last_f);
                chk.check_frame("frame", got_f, exp_f);
                last_f = exp_f;
                no_frame(2 * `SPARK_MAX);

                // bling on led3 with its enable low first
                @(posedge clk);
                take_bit(b);
                led_bling[0] <= b;
                take_bit(b);
                led_bling[2] <= b;
                take_bit(b);
                led_bling[3] <= b;
                led_bling[1] <= 1'b0;
                word.led3 = led_mode_pkg::LED_BLING;
                host_write(word);
                wait_frame(200, got_f, ok);
                exp_f = chk.ref_frame(word, last_f);
                chk.check_frame("frame", got_f, exp_f);
                last_f = exp_f;
                no_frame(4 * `SPARK_MAX);
                @(posedge clk);
                led_bling[1] <= 1'b1;
                count_flips(3, 4);

                $display("checks %0d, errors %0d", chk.checks, chk.errors);
                if (chk.errors == 0) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

endmodule

//--- tb.f
+incdir+.
led_mode_pkg.sv
led_link_pkg.sv
led_host_port.sv
led_ctrl.sv
led_shift.sv
led_panel_top.sv
tb_led_check.sv
tb_led_panel.sv
